/* hdl/jpeg_pkg.sv */
package jpeg_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] length_t;     // Byte counts, segment lengths, frame size
    typedef logic [8:0]  rom_addr_t;

    typedef enum logic [3:0] {
        seek_ff,
        read_code,
        len_hi,
        len_lo,
        skip_body,
        sof_body,
        sos_body,
        entropy,
        entropy_ff,
        done
    } parser_state_t;

    // Stored image
    localparam int IMAGE_BYTES  = 470;
    localparam int SOURCE_WORDS = 1 + (IMAGE_BYTES + 3) / 4;  // Length word plus data words
    localparam     IMAGE_FILE   = "hdl/jpeg_image.hex";

    // Marker codes
    localparam byte_t MARKER_PREFIX = 8'hFF;
    localparam byte_t MARKER_SOI    = 8'hD8;
    localparam byte_t MARKER_EOI    = 8'hD9;
    localparam byte_t MARKER_SOF0   = 8'hC0;
    localparam byte_t MARKER_SOS    = 8'hDA;

    // Idle cycles without a byte before the stream counts as ended
    localparam int STREAM_IDLE_LIMIT = 48;

endpackage

/* hdl/image_rom_source.sv */
module image_rom_source
    import jpeg_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    output word_t src_data,
    output logic  src_valid,
    input  logic  src_stall
);

    byte_t     rom [IMAGE_BYTES];
    logic [$clog2(SOURCE_WORDS + 1) - 1:0] word_cnt;
    rom_addr_t base_addr;

    initial begin
        $readmemh(IMAGE_FILE, rom);
    end

    function automatic byte_t rom_byte(input rom_addr_t addr);
        if (addr < IMAGE_BYTES) begin
            return rom[addr];
        end else begin
            return 8'h00;    // Padding past the end of file
        end
    endfunction

    assign src_valid = (word_cnt < SOURCE_WORDS);
    assign base_addr = rom_addr_t'({word_cnt - 1'b1, 2'b00});

    // Earliest file byte goes in the low bits
    always_comb begin
        if (word_cnt == '0) begin
            src_data = word_t'(IMAGE_BYTES);
        end else begin
            src_data = {rom_byte(base_addr + 9'd3),
                        rom_byte(base_addr + 9'd2),
                        rom_byte(base_addr + 9'd1),
                        rom_byte(base_addr)};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            word_cnt <= '0;
        end else if (src_valid && !src_stall) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    a_src_hold: assert property (
        @(posedge clock) disable iff (reset)
        src_valid && src_stall |=> $stable(src_data)
    ) else $error("src_data changed under stall");

endmodule

/* hdl/word_unpacker.sv */
module word_unpacker
    import jpeg_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  word_t src_data,
    input  logic  src_valid,
    output logic  src_stall,
    output byte_t byte_data,
    output logic  byte_valid,
    input  logic  byte_stall
);

    logic       have_len;
    length_t    remaining;     // File bytes not yet emitted
    word_t      shift_word;
    logic [1:0] buf_cnt;       // Bytes left in shift_word
    logic       out_free;
    logic       take_word;
    logic       take_len;
    logic       load_word;
    logic       next_byte;

    assign out_free  = !byte_valid || !byte_stall;

    // Once the count is spent, words are taken and dropped
    assign src_stall = have_len && (remaining != '0) && ((buf_cnt != '0) || !out_free);

    assign take_word = src_valid && !src_stall;
    assign take_len  = take_word && !have_len;
    assign load_word = take_word && have_len && (remaining != '0);
    assign next_byte = (buf_cnt != '0) && out_free;

    always_ff @(posedge clock) begin
        if (reset) begin
            have_len   <= 1'b0;
            remaining  <= '0;
            buf_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            if (take_len) begin
                have_len  <= 1'b1;
                remaining <= src_data[15:0];
            end
            if (load_word) begin
                remaining <= remaining - 16'd1;
                // Padding in the final word is never queued
                buf_cnt   <= (remaining > 16'd4) ? 2'd3 : 2'(remaining - 16'd1);
            end else if (next_byte) begin
                remaining <= remaining - 16'd1;
                buf_cnt   <= buf_cnt - 2'd1;
            end
            if (out_free) begin
                byte_valid <= load_word || next_byte;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load_word) begin
            byte_data  <= src_data[7:0];
            shift_word <= src_data >> 8;
        end else if (next_byte) begin
            byte_data  <= shift_word[7:0];
            shift_word <= shift_word >> 8;
        end
    end

endmodule

/* hdl/marker_parser.sv */
module marker_parser
    import jpeg_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  byte_t   byte_data,
    input  logic    byte_valid,
    output logic    byte_stall,
    output byte_t   ent_data,
    output logic    ent_valid,
    output logic    ent_last,
    input  logic    ent_stall,
    output length_t image_width,
    output length_t image_height,
    output byte_t   image_components,
    output logic    frame_info_valid,
    output logic    format_error
);

    parser_state_t state;
    byte_t         seg_code;
    length_t       seg_cnt;
    length_t       body_len;
    logic [2:0]    sof_idx;
    byte_t         hold_data;    // Newest entropy byte, sent once the next one is seen
    logic          hold_valid;
    logic [1:0]    lead_cnt;
    logic [5:0]    idle_cnt;
    logic          out_blocked;
    logic          replay;
    logic          step;
    logic          emit_hold;
    logic          last_flag;

    assign out_blocked = ent_valid && ent_stall;

    // FF followed by a non-EOI byte was data; the second byte is seen again next cycle
    assign replay     = byte_valid && (state == entropy_ff) && (byte_data != MARKER_EOI);
    assign byte_stall = out_blocked || replay;
    assign step       = byte_valid && !out_blocked;

    assign last_flag = (state == entropy_ff) && (byte_data == MARKER_EOI);
    assign emit_hold = step && hold_valid &&
                       (((state == entropy) && (byte_data != MARKER_PREFIX)) ||
                        (state == entropy_ff));

    assign body_len = length_t'({seg_cnt[15:8], byte_data} - 16'd2);

    always_ff @(posedge clock) begin
        if (reset) begin
            state            <= seek_ff;
            seg_code         <= '0;
            seg_cnt          <= '0;
            sof_idx          <= '0;
            hold_valid       <= 1'b0;
            ent_valid        <= 1'b0;
            ent_last         <= 1'b0;
            frame_info_valid <= 1'b0;
            format_error     <= 1'b0;
            lead_cnt         <= '0;
            idle_cnt         <= '0;
        end else begin
            if (!out_blocked) begin
                ent_valid <= emit_hold;
                ent_last  <= emit_hold && last_flag;
            end
            if (step) begin
                case (state)
                    seek_ff: begin
                        if (byte_data == MARKER_PREFIX) begin
                            state <= read_code;
                        end
                    end
                    read_code: begin
                        seg_code <= byte_data;
                        if (byte_data == MARKER_SOI) begin
                            state <= seek_ff;
                        end else if (byte_data == MARKER_EOI) begin
                            state <= done;
                        end else if (byte_data != MARKER_PREFIX) begin
                            state <= len_hi;    // Repeated FF is fill
                        end
                    end
                    len_hi: begin
                        seg_cnt <= {byte_data, 8'h00};
                        state   <= len_lo;
                    end
                    len_lo: begin
                        seg_cnt <= body_len;
                        sof_idx <= '0;
                        if (body_len == '0) begin
                            state <= (seg_code == MARKER_SOS) ? entropy : seek_ff;
                        end else if (seg_code == MARKER_SOF0) begin
                            state <= sof_body;
                        end else if (seg_code == MARKER_SOS) begin
                            state <= sos_body;
                        end else begin
                            state <= skip_body;
                        end
                    end
                    skip_body, sof_body, sos_body: begin
                        seg_cnt <= seg_cnt - 16'd1;
                        if (sof_idx != 3'd7) begin
                            sof_idx <= sof_idx + 3'd1;
                        end
                        if (seg_cnt == 16'd1) begin
                            state <= (state == sos_body) ? entropy : seek_ff;
                            if (state == sof_body) begin
                                frame_info_valid <= 1'b1;
                            end
                        end
                    end
                    entropy: begin
                        if (byte_data == MARKER_PREFIX) begin
                            state <= entropy_ff;
                        end else begin
                            hold_valid <= 1'b1;
                        end
                    end
                    entropy_ff: begin
                        if (byte_data == MARKER_EOI) begin
                            state      <= done;
                            hold_valid <= 1'b0;
                        end else begin
                            state      <= entropy;
                            hold_valid <= 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end

            // Stream must open with FF D8
            if (byte_valid && !byte_stall && (lead_cnt != 2'd2)) begin
                lead_cnt <= lead_cnt + 2'd1;
                if ((lead_cnt == 2'd0 && byte_data != MARKER_PREFIX) ||
                    (lead_cnt == 2'd1 && byte_data != MARKER_SOI)) begin
                    format_error <= 1'b1;
                end
            end

            // Bytes stopped before EOI
            if (byte_valid || (lead_cnt == 2'd0) || (state == done)) begin
                idle_cnt <= '0;
            end else if (idle_cnt == 6'(STREAM_IDLE_LIMIT)) begin
                format_error <= 1'b1;
            end else begin
                idle_cnt <= idle_cnt + 6'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (emit_hold) begin
            ent_data <= hold_data;
        end
        if (step && (state == entropy) && (byte_data != MARKER_PREFIX)) begin
            hold_data <= byte_data;
        end else if (replay && !out_blocked) begin
            hold_data <= MARKER_PREFIX;
        end
        if (step && (state == sof_body)) begin
            case (sof_idx)
                3'd1: image_height[15:8] <= byte_data;
                3'd2: image_height[7:0]  <= byte_data;
                3'd3: image_width[15:8]  <= byte_data;
                3'd4: image_width[7:0]   <= byte_data;
                3'd5: image_components   <= byte_data;
                default: begin
                end
            endcase
        end
    end

    a_no_header_output: assert property (
        @(posedge clock) disable iff (reset)
        ent_valid |-> (state inside {entropy, entropy_ff, done})
    ) else $error("entropy byte sent before scan data");

endmodule

/* hdl/word_packer.sv */
module word_packer
    import jpeg_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  byte_t ent_data,
    input  logic  ent_valid,
    input  logic  ent_last,
    output logic  ent_stall,
    output word_t out_data,
    output logic  out_valid,
    output logic  out_last,
    input  logic  downstream_stall
);

    word_t      acc;
    word_t      packed_word;
    logic [1:0] acc_cnt;       // Bytes already in acc
    logic       out_free;
    logic       take;
    logic       flush;

    assign out_free  = !out_valid || !downstream_stall;
    assign ent_stall = !out_free;
    assign take      = ent_valid && out_free;
    assign flush     = take && ((acc_cnt == 2'd3) || ent_last);

    // New byte lands at acc_cnt, bytes above it read as zero
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (i < acc_cnt) begin
                packed_word[i*8 +: 8] = acc[i*8 +: 8];
            end else if (i == acc_cnt) begin
                packed_word[i*8 +: 8] = ent_data;
            end else begin
                packed_word[i*8 +: 8] = 8'h00;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            acc_cnt   <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            if (take) begin
                acc_cnt <= flush ? 2'd0 : acc_cnt + 2'd1;
            end
            if (out_free) begin
                out_valid <= flush;
                out_last  <= flush && ent_last;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            acc <= packed_word;
        end
        if (flush) begin
            out_data <= packed_word;
        end
    end

    a_out_hold: assert property (
        @(posedge clock) disable iff (reset)
        out_valid && downstream_stall |=> $stable(out_data)
    ) else $error("out_data changed under stall");

endmodule

/* hdl/jpeg_preproc_top.sv */
module jpeg_preproc_top
    import jpeg_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    downstream_stall,
    output word_t   out_data,
    output logic    out_valid,
    output logic    out_last,
    output length_t image_width,
    output length_t image_height,
    output byte_t   image_components,
    output logic    frame_info_valid,
    output logic    format_error
);

    word_t src_data;
    logic  src_valid;
    logic  src_stall;
    byte_t byte_data;
    logic  byte_valid;
    logic  byte_stall;
    byte_t ent_data;
    logic  ent_valid;
    logic  ent_last;
    logic  ent_stall;

    image_rom_source u_image_rom_source (
        .clock     (clock),
        .reset     (reset),
        .src_data  (src_data),
        .src_valid (src_valid),
        .src_stall (src_stall)
    );

    word_unpacker u_word_unpacker (
        .clock      (clock),
        .reset      (reset),
        .src_data   (src_data),
        .src_valid  (src_valid),
        .src_stall  (src_stall),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_stall (byte_stall)
    );

    marker_parser u_marker_parser (
        .clock            (clock),
        .reset            (reset),
        .byte_data        (byte_data),
        .byte_valid       (byte_valid),
        .byte_stall       (byte_stall),
        .ent_data         (ent_data),
        .ent_valid        (ent_valid),
        .ent_last         (ent_last),
        .ent_stall        (ent_stall),
        .image_width      (image_width),
        .image_height     (image_height),
        .image_components (image_components),
        .frame_info_valid (frame_info_valid),
        .format_error     (format_error)
    );

    word_packer u_word_packer (
        .clock            (clock),
        .reset            (reset),
        .ent_data         (ent_data),
        .ent_valid        (ent_valid),
        .ent_last         (ent_last),
        .ent_stall        (ent_stall),
        .out_data         (out_data),
        .out_valid        (out_valid),
        .out_last         (out_last),
        .downstream_stall (downstream_stall)
    );

endmodule

/* sim/tb_jpeg_preproc.sv */
module tb_jpeg_preproc
    import jpeg_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WORDS_BASE   = 4;
    localparam int STALL_BASE   = 25;
    localparam int DATA_ENTRIES = 89;
    localparam int WAIT_LIMIT   = 5000;   // Cycles per wait loop
    localparam int DRAIN_CYCLES = 40;

    logic    clock;
    logic    reset;
    logic    downstream_stall;
    word_t   out_data;
    logic    out_valid;
    logic    out_last;
    length_t image_width;
    length_t image_height;
    byte_t   image_components;
    logic    frame_info_valid;
    logic    format_error;

    logic [31:0] tdata [DATA_ENTRIES];
    int          errors;
    int          checks;
    int          rx_count;
    int          stall_idx;
    logic        last_seen;
    logic        prev_hold;
    word_t       prev_data;

    jpeg_preproc_top u_jpeg_preproc_top (
        .clock            (clock),
        .reset            (reset),
        .downstream_stall (downstream_stall),
        .out_data         (out_data),
        .out_valid        (out_valid),
        .out_last         (out_last),
        .image_width      (image_width),
        .image_height     (image_height),
        .image_components (image_components),
        .frame_info_valid (frame_info_valid),
        .format_error     (format_error)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // Stall pattern restarts from entry 0 on the first cycle after reset
    always @(posedge clock) begin
        if (reset) begin
            stall_idx        <= 0;
            downstream_stall <= 1'b0;
        end else begin
            downstream_stall <= tdata[STALL_BASE + stall_idx][0];
            stall_idx        <= (stall_idx + 1) % 64;
        end
    end

    // Values read here are the ones settled before this edge
    always @(posedge clock) begin
        if (!reset) begin
            check_value("format_error", 32'd0, 32'(format_error));
            if (prev_hold) begin
                check_value("out_data hold", prev_data, out_data);
            end
            prev_hold <= out_valid && downstream_stall;
            prev_data <= out_data;
            if (last_seen) begin
                check_value("out_valid after last", 32'd0, 32'(out_valid));
            end else if (out_valid && !downstream_stall) begin
                checks++;
                assert (rx_count < int'(tdata[3])) else begin
                    errors++;
                    $display("more output words than expected");
                end
                if (rx_count < int'(tdata[3])) begin
                    check_value($sformatf("word %0d", rx_count),
                                tdata[WORDS_BASE + rx_count], out_data);
                    check_value($sformatf("out_last on word %0d", rx_count),
                                32'(rx_count == int'(tdata[3]) - 1), 32'(out_last));
                end
                if (out_last) begin
                    last_seen <= 1'b1;
                end
                rx_count <= rx_count + 1;
            end
        end
    end

    initial begin
        int cycles;

        errors           = 0;
        checks           = 0;
        rx_count         = 0;
        last_seen        = 1'b0;
        prev_hold        = 1'b0;
        prev_data        = '0;
        reset            = 1'b1;
        downstream_stall = 1'b0;
        $readmemh("sim/jpeg_testdata.txt", tdata);

        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("out_valid after reset", 32'd0, 32'(out_valid));
        check_value("out_last after reset", 32'd0, 32'(out_last));
        check_value("frame_info_valid after reset", 32'd0, 32'(frame_info_valid));
        check_value("format_error after reset", 32'd0, 32'(format_error));

        cycles = 0;
        while (!frame_info_valid && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end

        checks++;
        assert (frame_info_valid) else begin
            errors++;
            $display("timeout waiting for frame_info_valid");
        end

        if (frame_info_valid) begin
            check_value("image_width", tdata[0], 32'(image_width));
            check_value("image_height", tdata[1], 32'(image_height));
            check_value("image_components", tdata[2], 32'(image_components));

            cycles = 0;
            while (!last_seen && cycles < WAIT_LIMIT) begin
                @(negedge clock);
                cycles++;
            end

            checks++;
            assert (last_seen) else begin
                errors++;
                $display("timeout waiting for the last output word");
            end

            if (last_seen) begin
                repeat (DRAIN_CYCLES) @(negedge clock);
                check_value("word count", tdata[3], 32'(rx_count));
            end
        end

        finish_run();
    end

endmodule

/* compile.f */
hdl/jpeg_pkg.sv
hdl/image_rom_source.sv
hdl/word_unpacker.sv
hdl/marker_parser.sv
hdl/word_packer.sv
hdl/jpeg_preproc_top.sv
sim/tb_jpeg_preproc.sv

/* hdl/jpeg_image.hex */
FF D8 FF E0 00 10 4A 46 49 46 00 01 01 00 00 01
00 01 00 00 FF DB 00 84 00 08 08 08 08 08 08 08
08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08
08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08
08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08
08 08 08 08 08 08 08 08 08 01 0C 0C 0C 0C 0C 0C
0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C
0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C
0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C 0C
0C 0C 0C 0C 0C 0C 0C 0C 0C 0C FF C0 00 0B 08 00
1C 00 1C 01 01 11 00 FF C4 00 1F 00 00 01 05 01
01 01 01 01 01 00 00 00 00 00 00 00 00 01 02 03
04 05 06 07 08 09 0A 0B FF C4 00 AF 10 00 02 01
03 03 02 04 03 05 05 04 04 00 00 01 77 01 02 03
04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11 12 13
14 15 16 17 18 19 1A 1B 1C 1D 1E 1F 20 21 22 23
24 25 26 27 28 29 2A 2B 2C 2D 2E 2F 30 31 32 33
34 35 36 37 38 39 3A 3B 3C 3D 3E 3F 40 41 42 43
44 45 46 47 48 49 4A 4B 4C 4D 4E 4F 50 51 52 53
54 55 56 57 58 59 5A 5B 5C 5D 5E 5F 60 61 62 63
64 65 66 67 68 69 6A 6B 6C 6D 6E 6F 70 71 72 73
74 75 76 77 78 79 7A 7B 7C 7D 7E 7F 80 81 82 83
84 85 86 87 88 89 8A 8B 8C 8D 8E 8F 90 91 92 93
94 95 96 97 98 99 9A 9B 9C FF DA 00 08 01 01 00
00 3F 00 3C 4D 5E 6F 80 91 A2 B3 C4 D5 E6 F7 08
19 2A 3B 4C 5D 6E 7F 90 A1 B2 C3 D4 E5 F6 07 18
29 3A 4B 5C 6D 7E 8F A0 B1 C2 D3 E4 F5 06 17 28
39 4A 5B 6C 7D 8E 9F B0 C1 D2 E3 F4 05 16 27 38
49 5A 6B 7C 8D 9E AF C0 D1 E2 F3 04 15 26 37 48
59 6A 7B 8C FF D9

/* sim/jpeg_testdata.txt */
// Entries 0-2: width, height, components. Entry 3: number of output words.
// Entries 4-24: output words in order. Entries 25-88: downstream_stall pattern.
0000001C
0000001C
00000001
00000015
6F5E4D3C
B3A29180
F7E6D5C4
3B2A1908
7F6E5D4C
C3B2A190
07F6E5D4
4B3A2918
8F7E6D5C
D3C2B1A0
1706F5E4
5B4A3928
9F8E7D6C
E3D2C1B0
271605F4
6B5A4938
AF9E8D7C
F3E2D1C0
37261504
7B6A5948
0000008C
0 0 1 0 1 1 0 0 0 1 0 0 1 1 1 0
0 1 0 0 0 0 1 0 1 0 1 1 0 0 0 1
1 0 0 1 0 0 0 0 1 1 0 1 0 0 1 0
0 0 0 1 1 1 1 0 0 1 0 0 0 1 0 0
